/* hw/cp_params.svh */
// Control path sizes, instruction field layout and config address map
// shared by the barrel processor RTL

`ifndef CP_PARAMS_SVH
`define CP_PARAMS_SVH

// Datapath widths
`define CP_WORD_WIDTH           32
`define CP_ADDR_WIDTH           10
`define CP_PC_WIDTH             8
`define CP_IM_DEPTH             256

// Threads, each starting at its own stride in instruction memory
`define CP_THREAD_COUNT         4
`define CP_THREAD_WIDTH         2
`define CP_THREAD_PC_STRIDE     64

// Instruction fields, MSB first: opcode, D, A, B
`define CP_OPCODE_WIDTH         4
`define CP_D_WIDTH              10
`define CP_A_WIDTH              9
`define CP_B_WIDTH              9
`define CP_ALU_CTRL_WIDTH       12
`define CP_OD_THREAD_DEPTH      16

// Branch table
`define CP_BRANCH_COUNT         2
`define CP_BT_ENTRIES           8
`define CP_COND_WIDTH           3

// Config address map
`define CP_IM_BASE              0
`define CP_OD_BASE              256
`define CP_BT_BASE              320
`define CP_DB_BASE_ADDR         512

`endif

/* hw/cp_pkg.sv */
// Shared types of the barrel processor control path

`default_nettype none

`include "cp_params.svh"

package cp_pkg;

    // Buses and addresses
    typedef logic [`CP_WORD_WIDTH-1:0]      cp_word_t;
    typedef logic [`CP_ADDR_WIDTH-1:0]      cp_addr_t;
    typedef logic [`CP_PC_WIDTH-1:0]        cp_pc_t;
    typedef logic [`CP_THREAD_WIDTH-1:0]    cp_thread_t;

    // Instruction fields and decoded control
    typedef logic [`CP_OPCODE_WIDTH-1:0]    cp_opcode_t;
    typedef logic [`CP_D_WIDTH-1:0]         cp_d_operand_t;
    typedef logic [`CP_A_WIDTH-1:0]         cp_src_operand_t;
    typedef logic [`CP_ALU_CTRL_WIDTH-1:0]  cp_alu_ctrl_t;

    // Branch condition select, same encoding as the branch entry field
    typedef enum logic [`CP_COND_WIDTH-1:0] {
        COND_ALWAYS,
        COND_NEGATIVE,
        COND_CARRYOUT,
        COND_A_EXTERNAL,
        COND_LESSTHAN,
        COND_B_EXTERNAL,
        COND_ZERO,
        COND_NEVER
    } cp_branch_cond_t;

endpackage

`default_nettype wire

/* hw/thread_scheduler.sv */
// Round-robin slot scheduler for the hardware threads
// Also decodes the config address map into memory write enables

`timescale 1ns/10ps
`default_nettype none

`include "cp_params.svh"

module thread_scheduler (
    input  wire                     clock,
    input  wire                     rst_n,
    input  wire                     config_write,
    input  wire                     cancel_previous,
    input  wire cp_pkg::cp_addr_t   config_addr,
    output cp_pkg::cp_thread_t      slot_thread,
    output logic                    pipe_valid,
    output logic                    im_we,
    output logic                    od_we,
    output logic                    bt_we
);

    localparam int IM_END = `CP_IM_BASE + `CP_IM_DEPTH;
    localparam int OD_END = `CP_OD_BASE + `CP_THREAD_COUNT * `CP_OD_THREAD_DEPTH;
    localparam int BT_END = `CP_BT_BASE + `CP_BT_ENTRIES;

    logic write_ok;
    int   addr_i;

    // ------------------------------------------------------------
    // Slot counter and fill flag

    // pipe_valid marks the fetch stage as holding a real slot
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            slot_thread <= '0;
            pipe_valid  <= 1'b0;
        end else begin
            pipe_valid <= 1'b1;
            if (slot_thread == cp_pkg::cp_thread_t'(`CP_THREAD_COUNT - 1)) begin
                slot_thread <= '0;
            end else begin
                slot_thread <= slot_thread + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Config window decode

    assign write_ok = config_write && !cancel_previous;
    assign addr_i   = int'(config_addr);

    assign im_we = write_ok && (addr_i >= `CP_IM_BASE) && (addr_i < IM_END);
    assign od_we = write_ok && (addr_i >= `CP_OD_BASE) && (addr_i < OD_END);
    assign bt_we = write_ok && (addr_i >= `CP_BT_BASE) && (addr_i < BT_END);

    // A write strobe comes with a defined qualifier and address
    cfg_known: assert property (@(posedge clock) disable iff (!rst_n)
        config_write |-> !$isunknown({cancel_previous, config_addr}));

endmodule

`default_nettype wire

/* hw/pc_store.sv */
// Per-thread program counters of the barrel processor
// The slot's PC is read out combinationally and written back with fetch_pc + 1

`timescale 1ns/10ps
`default_nettype none

`include "cp_params.svh"

module pc_store (
    input  wire                     clock,
    input  wire                     rst_n,
    input  wire cp_pkg::cp_thread_t slot_thread,
    input  wire cp_pkg::cp_pc_t     fetch_pc,
    output cp_pkg::cp_pc_t          current_pc
);

    cp_pkg::cp_pc_t pc_q [`CP_THREAD_COUNT];
    cp_pkg::cp_pc_t next_pc;

    // ------------------------------------------------------------
    // Read side

    // Feeds the branch unit in the same slot
    assign current_pc = pc_q[slot_thread];

    // Wraps modulo the instruction memory depth
    assign next_pc = fetch_pc + cp_pkg::cp_pc_t'(1);

    // ------------------------------------------------------------
    // Write back

    // Each thread starts in its own region of instruction memory
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < `CP_THREAD_COUNT; t++) begin
                pc_q[t] <= cp_pkg::cp_pc_t'(t * `CP_THREAD_PC_STRIDE);
            end
        end else begin
            // Only the thread in the current slot advances
            pc_q[slot_thread] <= next_pc;
        end
    end

    // Each thread gets exactly one slot per round
    slot_in_turn: assert property (@(posedge clock) disable iff (!rst_n)
        $past(rst_n) |->
            (int'(slot_thread) == (int'($past(slot_thread)) + 1) % `CP_THREAD_COUNT));

endmodule

`default_nettype wire

/* hw/branch_unit.sv */
// Branch table and fetch address select of the barrel processor
// Evaluates the slot thread's entries against flags from its previous result

`timescale 1ns/10ps
`default_nettype none

`include "cp_params.svh"

module branch_unit (
    input  wire                     clock,
    input  wire                     rst_n,
    input  wire cp_pkg::cp_thread_t slot_thread,
    input  wire cp_pkg::cp_pc_t     current_pc,
    input  wire                     bt_we,
    input  wire cp_pkg::cp_addr_t   config_addr,
    input  wire cp_pkg::cp_word_t   config_data,
    input  wire                     carryout,
    input  wire                     overflow,
    input  wire                     a_external,
    input  wire                     b_external,
    input  wire cp_pkg::cp_word_t   r_previous,
    output cp_pkg::cp_pc_t          fetch_pc,
    output logic                    branch_cancel
);

    // Branch entry layout in config data
    localparam int DEST_LSB   = `CP_PC_WIDTH;
    localparam int COND_LSB   = 2 * `CP_PC_WIDTH;
    localparam int CANCEL_BIT = COND_LSB + `CP_COND_WIDTH;
    localparam int ENABLE_BIT = CANCEL_BIT + 1;
    localparam int IDX_WIDTH  = $clog2(`CP_BT_ENTRIES);

    logic [IDX_WIDTH-1:0]       wr_idx;
    logic                       bt_enable [`CP_BT_ENTRIES];
    logic                       bt_cancel [`CP_BT_ENTRIES];
    cp_pkg::cp_pc_t             bt_origin [`CP_BT_ENTRIES];
    cp_pkg::cp_pc_t             bt_dest   [`CP_BT_ENTRIES];
    cp_pkg::cp_branch_cond_t    bt_cond   [`CP_BT_ENTRIES];

    logic                               negative;
    logic                               lessthan;
    logic                               zero;
    logic [(1 << `CP_COND_WIDTH)-1:0]   cond_true;

    // ------------------------------------------------------------
    // Branch table, entry index is {thread, slot}

    assign wr_idx = config_addr[IDX_WIDTH-1:0];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int e = 0; e < `CP_BT_ENTRIES; e++) begin
                bt_enable[e] <= 1'b0;
            end
        end else if (bt_we) begin
            bt_enable[wr_idx] <= config_data[ENABLE_BIT];
        end
    end

    always_ff @(posedge clock) begin
        if (bt_we) begin
            bt_origin[wr_idx] <= config_data[0 +: `CP_PC_WIDTH];
            bt_dest[wr_idx]   <= config_data[DEST_LSB +: `CP_PC_WIDTH];
            bt_cond[wr_idx]   <= cp_pkg::cp_branch_cond_t'(config_data[COND_LSB +: `CP_COND_WIDTH]);
            bt_cancel[wr_idx] <= config_data[CANCEL_BIT];
        end
    end

    // ------------------------------------------------------------
    // Flags of the thread's previous result

    assign negative = r_previous[`CP_WORD_WIDTH-1];
    assign lessthan = overflow ^ negative;
    assign zero     = (r_previous == '0);

    always_comb begin
        cond_true                           = '0;
        cond_true[cp_pkg::COND_ALWAYS]      = 1'b1;
        cond_true[cp_pkg::COND_NEGATIVE]    = negative;
        cond_true[cp_pkg::COND_CARRYOUT]    = carryout;
        cond_true[cp_pkg::COND_A_EXTERNAL]  = a_external;
        cond_true[cp_pkg::COND_LESSTHAN]    = lessthan;
        cond_true[cp_pkg::COND_B_EXTERNAL]  = b_external;
        cond_true[cp_pkg::COND_ZERO]        = zero;
        cond_true[cp_pkg::COND_NEVER]       = 1'b0;
    end

    // Walk slots high to low so that slot 0 wins
    always_comb begin
        int idx;
        fetch_pc      = current_pc;
        branch_cancel = 1'b0;
        for (int s = `CP_BRANCH_COUNT - 1; s >= 0; s--) begin
            idx = int'(slot_thread) * `CP_BRANCH_COUNT + s;
            if (bt_enable[idx] && (bt_origin[idx] == current_pc) && cond_true[bt_cond[idx]]) begin
                fetch_pc      = bt_dest[idx];
                branch_cancel = bt_cancel[idx];
            end
        end
    end

    // Scheduler-decoded table writes carry a defined condition code
    cond_known: assert property (@(posedge clock) disable iff (!rst_n)
        bt_we |-> !$isunknown(config_data[COND_LSB +: `CP_COND_WIDTH]));

endmodule

`default_nettype wire

/* hw/instr_fetch_decode.sv */
// Shared instruction memory and per-thread opcode decoder of the barrel processor
// Two registered stages: instruction read, then decode and operand extraction

`timescale 1ns/10ps
`default_nettype none

`include "cp_params.svh"

module instr_fetch_decode (
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire cp_pkg::cp_thread_t     slot_thread,
    input  wire cp_pkg::cp_pc_t         fetch_pc,
    input  wire                         branch_cancel,
    input  wire                         pipe_valid,
    input  wire                         im_we,
    input  wire                         od_we,
    input  wire cp_pkg::cp_addr_t       config_addr,
    input  wire cp_pkg::cp_word_t       config_data,
    output logic                        out_valid,
    output cp_pkg::cp_thread_t          out_thread,
    output logic                        cancel,
    output cp_pkg::cp_alu_ctrl_t        alu_control,
    output cp_pkg::cp_d_operand_t       da,
    output cp_pkg::cp_d_operand_t       db,
    output cp_pkg::cp_src_operand_t     a,
    output cp_pkg::cp_src_operand_t     b
);

    localparam int D_LSB      = `CP_A_WIDTH + `CP_B_WIDTH;
    localparam int OPCODE_LSB = `CP_WORD_WIDTH - `CP_OPCODE_WIDTH;

    cp_pkg::cp_word_t       im_mem [`CP_IM_DEPTH];
    cp_pkg::cp_alu_ctrl_t   od_mem [`CP_THREAD_COUNT][`CP_OD_THREAD_DEPTH];

    cp_pkg::cp_word_t           s1_instr;
    cp_pkg::cp_thread_t         s1_thread;
    logic                       s1_cancel;
    cp_pkg::cp_opcode_t         s1_opcode;
    cp_pkg::cp_d_operand_t      s1_d;
    cp_pkg::cp_src_operand_t    s1_a;
    cp_pkg::cp_src_operand_t    s1_b;

    initial begin
        for (int i = 0; i < `CP_IM_DEPTH; i++) begin
            im_mem[i] = '0;
        end
        for (int t = 0; t < `CP_THREAD_COUNT; t++) begin
            for (int o = 0; o < `CP_OD_THREAD_DEPTH; o++) begin
                od_mem[t][o] = '0;
            end
        end
    end

    // ------------------------------------------------------------
    // Config writes, both windows are base aligned

    always_ff @(posedge clock) begin
        if (im_we) begin
            im_mem[config_addr[`CP_PC_WIDTH-1:0]] <= config_data;
        end
        if (od_we) begin
            od_mem[config_addr[`CP_OPCODE_WIDTH +: `CP_THREAD_WIDTH]]
                  [config_addr[`CP_OPCODE_WIDTH-1:0]] <= config_data[`CP_ALU_CTRL_WIDTH-1:0];
        end
    end

    // ------------------------------------------------------------
    // Stage 1: instruction read

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            s1_instr  <= '0;
            s1_thread <= '0;
            s1_cancel <= 1'b0;
        end else begin
            s1_instr  <= im_mem[fetch_pc];
            s1_thread <= slot_thread;
            s1_cancel <= branch_cancel;
        end
    end

    assign s1_opcode = s1_instr[OPCODE_LSB +: `CP_OPCODE_WIDTH];
    assign s1_d      = s1_instr[D_LSB +: `CP_D_WIDTH];
    assign s1_a      = s1_instr[`CP_B_WIDTH +: `CP_A_WIDTH];
    assign s1_b      = s1_instr[`CP_B_WIDTH-1:0];

    // ------------------------------------------------------------
    // Stage 2: decode and operands

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            out_thread  <= '0;
            cancel      <= 1'b0;
            alu_control <= '0;
            da          <= '0;
            db          <= '0;
            a           <= '0;
            b           <= '0;
        end else begin
            // pipe_valid qualifies the slot now in stage 1
            out_valid   <= pipe_valid;
            out_thread  <= s1_thread;
            cancel      <= s1_cancel;
            alu_control <= od_mem[s1_thread][s1_opcode];
            da          <= s1_d;
            db          <= s1_d + cp_pkg::cp_d_operand_t'(`CP_DB_BASE_ADDR);
            a           <= s1_a;
            b           <= s1_b;
        end
    end

endmodule

`default_nettype wire

/* hw/controlpath.sv */
// Top of the barrel processor control path
// Scheduler, PC store, branch unit and fetch/decode pipeline

`timescale 1ns/10ps
`default_nettype none

module controlpath (
    input  wire                             clock,
    input  wire                             rst_n,

    // Config port
    input  wire                             config_write,
    input  wire                             cancel_previous,
    input  wire cp_pkg::cp_addr_t           config_addr,
    input  wire cp_pkg::cp_word_t           config_data,

    // Flags of the thread in the current slot
    input  wire                             carryout,
    input  wire                             overflow,
    input  wire                             a_external,
    input  wire                             b_external,
    input  wire cp_pkg::cp_word_t           r_previous,

    // Decoded instruction, two cycles after its slot
    output wire                             out_valid,
    output wire cp_pkg::cp_thread_t         out_thread,
    output wire                             cancel,
    output wire cp_pkg::cp_alu_ctrl_t       alu_control,
    output wire cp_pkg::cp_d_operand_t      da,
    output wire cp_pkg::cp_d_operand_t      db,
    output wire cp_pkg::cp_src_operand_t    a,
    output wire cp_pkg::cp_src_operand_t    b
);

    wire cp_pkg::cp_thread_t    slot_thread;
    wire cp_pkg::cp_pc_t        current_pc;
    wire cp_pkg::cp_pc_t        fetch_pc;
    wire                        pipe_valid;
    wire                        im_we;
    wire                        od_we;
    wire                        bt_we;
    wire                        branch_cancel;

    // ------------------------------------------------------------

    thread_scheduler sched (
        .clock           (clock),
        .rst_n           (rst_n),
        .config_write    (config_write),
        .cancel_previous (cancel_previous),
        .config_addr     (config_addr),
        .slot_thread     (slot_thread),
        .pipe_valid      (pipe_valid),
        .im_we           (im_we),
        .od_we           (od_we),
        .bt_we           (bt_we)
    );

    pc_store pcs (
        .clock       (clock),
        .rst_n       (rst_n),
        .slot_thread (slot_thread),
        .fetch_pc    (fetch_pc),
        .current_pc  (current_pc)
    );

    branch_unit branch (
        .clock         (clock),
        .rst_n         (rst_n),
        .slot_thread   (slot_thread),
        .current_pc    (current_pc),
        .bt_we         (bt_we),
        .config_addr   (config_addr),
        .config_data   (config_data),
        .carryout      (carryout),
        .overflow      (overflow),
        .a_external    (a_external),
        .b_external    (b_external),
        .r_previous    (r_previous),
        .fetch_pc      (fetch_pc),
        .branch_cancel (branch_cancel)
    );

    // ------------------------------------------------------------

    instr_fetch_decode ifd (
        .clock         (clock),
        .rst_n         (rst_n),
        .slot_thread   (slot_thread),
        .fetch_pc      (fetch_pc),
        .branch_cancel (branch_cancel),
        .pipe_valid    (pipe_valid),
        .im_we         (im_we),
        .od_we         (od_we),
        .config_addr   (config_addr),
        .config_data   (config_data),
        .out_valid     (out_valid),
        .out_thread    (out_thread),
        .cancel        (cancel),
        .alu_control   (alu_control),
        .da            (da),
        .db            (db),
        .a             (a),
        .b             (b)
    );

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
// Testbench clock and reset source
// 8 ns clock, reset held low for the first 8 rising edges

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        rst_n = 1'b0;
        repeat (8) @(posedge clock);
        rst_n <= 1'b1;
    end

    always #4 clock = ~clock;

endmodule

`default_nettype wire

/* dv/controlpath_tb.sv */
// Directed and random tests of the barrel processor control path
// A cycle model of PCs, memories and branch tables predicts every output slot

`timescale 1ns/10ps
`default_nettype none

`include "cp_params.svh"

module controlpath_tb;

    logic                       clock;
    logic                       rst_n;
    logic                       config_write;
    logic                       cancel_previous;
    cp_pkg::cp_addr_t           config_addr;
    cp_pkg::cp_word_t           config_data;
    logic                       carryout;
    logic                       overflow;
    logic                       a_external;
    logic                       b_external;
    cp_pkg::cp_word_t           r_previous;
    wire                        out_valid;
    wire cp_pkg::cp_thread_t    out_thread;
    wire                        cancel;
    wire cp_pkg::cp_alu_ctrl_t  alu_control;
    wire cp_pkg::cp_d_operand_t da;
    wire cp_pkg::cp_d_operand_t db;
    wire cp_pkg::cp_src_operand_t a;
    wire cp_pkg::cp_src_operand_t b;

    // Values for the next cycle, driven by step
    logic d_cw;
    logic d_cp;
    logic d_co;
    logic d_ov;
    logic d_ae;
    logic d_be;
    cp_pkg::cp_addr_t d_ca;
    cp_pkg::cp_word_t d_cd;
    cp_pkg::cp_word_t d_r;

    // ------------------------------------------------------------
    // Reference model state

    cp_pkg::cp_word_t           m_im [256];
    cp_pkg::cp_alu_ctrl_t       m_od [4][16];
    cp_pkg::cp_pc_t             m_pc [4];
    logic                       m_en [8];
    logic                       m_can [8];
    cp_pkg::cp_pc_t             m_org [8];
    cp_pkg::cp_pc_t             m_dst [8];
    cp_pkg::cp_branch_cond_t    m_cond [8];
    int                         ncyc;
    // Stage 1 and output expectations
    cp_pkg::cp_word_t           s1_instr;
    cp_pkg::cp_thread_t         s1_thread;
    logic                       s1_cancel;
    logic                       e_valid;
    logic                       e_cancel;
    cp_pkg::cp_thread_t         e_thread;
    cp_pkg::cp_alu_ctrl_t       e_alu;
    cp_pkg::cp_d_operand_t      e_da;
    cp_pkg::cp_d_operand_t      e_db;
    cp_pkg::cp_src_operand_t    e_a;
    cp_pkg::cp_src_operand_t    e_b;

    tb_clock_gen clkgen (.clock(clock), .rst_n(rst_n));

    controlpath dut0 (
        .clock(clock), .rst_n(rst_n),
        .config_write(config_write), .cancel_previous(cancel_previous),
        .config_addr(config_addr), .config_data(config_data),
        .carryout(carryout), .overflow(overflow),
        .a_external(a_external), .b_external(b_external), .r_previous(r_previous),
        .out_valid(out_valid), .out_thread(out_thread), .cancel(cancel),
        .alu_control(alu_control), .da(da), .db(db), .a(a), .b(b)
    );

    // ------------------------------------------------------------
    // Failure reporting and compare tasks

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_thread(input cp_pkg::cp_thread_t got, input cp_pkg::cp_thread_t exp,
                                input string what);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic check_alu_control(input cp_pkg::cp_alu_ctrl_t got,
                                     input cp_pkg::cp_alu_ctrl_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_d_operand(input cp_pkg::cp_d_operand_t got,
                                   input cp_pkg::cp_d_operand_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_src_operand(input cp_pkg::cp_src_operand_t got,
                                     input cp_pkg::cp_src_operand_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic compare_outputs();
        check_bit(out_valid, e_valid, "out_valid");
        check_bit(cancel, e_cancel, "cancel");
        check_thread(out_thread, e_thread, "out_thread");
        check_alu_control(alu_control, e_alu, "alu_control");
        check_d_operand(da, e_da, "da");
        check_d_operand(db, e_db, "db");
        check_src_operand(a, e_a, "a");
        check_src_operand(b, e_b, "b");
    endtask

    // ------------------------------------------------------------
    // Reference model called once per clock cycle

    function automatic logic cond_holds(input cp_pkg::cp_branch_cond_t c);
        logic neg;
        neg = d_r[31];
        case (c)
            cp_pkg::COND_ALWAYS:     return 1'b1;
            cp_pkg::COND_NEGATIVE:   return neg;
            cp_pkg::COND_CARRYOUT:   return d_co;
            cp_pkg::COND_A_EXTERNAL: return d_ae;
            cp_pkg::COND_LESSTHAN:   return d_ov ^ neg;
            cp_pkg::COND_B_EXTERNAL: return d_be;
            cp_pkg::COND_ZERO:       return d_r == 32'd0;
            default:                 return 1'b0;
        endcase
    endfunction

    task automatic model_cycle();
        cp_pkg::cp_thread_t t;
        cp_pkg::cp_pc_t     fpc;
        logic               fcan;
        logic               found;
        int                 idx;
        int                 addr;
        // Stage 2 reads the decoder before this cycle's write lands
        e_valid  = (ncyc >= 1);
        e_thread = s1_thread;
        e_cancel = s1_cancel;
        e_alu    = m_od[s1_thread][s1_instr[31:28]];
        e_da     = s1_instr[27:18];
        e_db     = s1_instr[27:18] + 10'd512;
        e_a      = s1_instr[17:9];
        e_b      = s1_instr[8:0];
        // Fetch for this slot with entry 0 checked first
        t     = cp_pkg::cp_thread_t'(ncyc % 4);
        fpc   = m_pc[t];
        fcan  = 1'b0;
        found = 1'b0;
        for (int s = 0; s < 2; s++) begin
            idx = int'(t) * 2 + s;
            if (!found && m_en[idx] && m_org[idx] == m_pc[t] && cond_holds(m_cond[idx])) begin
                fpc   = m_dst[idx];
                fcan  = m_can[idx];
                found = 1'b1;
            end
        end
        s1_instr  = m_im[fpc];
        s1_thread = t;
        s1_cancel = fcan;
        m_pc[t]   = fpc + 8'd1;
        // Config write applies at the end of the cycle
        addr = int'(d_ca);
        if (d_cw && !d_cp) begin
            if (addr < 256) begin
                m_im[addr] = d_cd;
            end else if (addr < 320) begin
                m_od[addr[5:4]][addr[3:0]] = d_cd[11:0];
            end else if (addr < 328) begin
                m_en[addr[2:0]]   = d_cd[20];
                m_can[addr[2:0]]  = d_cd[19];
                m_cond[addr[2:0]] = cp_pkg::cp_branch_cond_t'(d_cd[18:16]);
                m_dst[addr[2:0]]  = d_cd[15:8];
                m_org[addr[2:0]]  = d_cd[7:0];
            end
        end
        ncyc++;
    endtask

    // ------------------------------------------------------------
    // Stimulus helpers

    task automatic step();
        @(posedge clock);
        config_write    <= d_cw;
        cancel_previous <= d_cp;
        config_addr     <= d_ca;
        config_data     <= d_cd;
        carryout        <= d_co;
        overflow        <= d_ov;
        a_external      <= d_ae;
        b_external      <= d_be;
        r_previous      <= d_r;
        @(negedge clock);
        compare_outputs();
        model_cycle();
        d_cw = 1'b0;
        d_cp = 1'b0;
    endtask

    task automatic run_cycles(input int n);
        repeat (n) step();
    endtask

    task automatic cfg_write(input int addr, input cp_pkg::cp_word_t data, input logic suppress);
        d_cw = 1'b1;
        d_cp = suppress;
        d_ca = cp_pkg::cp_addr_t'(addr);
        d_cd = data;
        step();
    endtask

    function automatic cp_pkg::cp_word_t make_entry(input logic en, input logic can,
            input cp_pkg::cp_branch_cond_t c, input cp_pkg::cp_pc_t dst, input cp_pkg::cp_pc_t org);
        return {11'd0, en, can, c, dst, org};
    endfunction

    // Entry three fetches ahead of the thread's PC and then let it pass
    task automatic branch_ahead(input int t, input int s, input logic can,
                                input cp_pkg::cp_branch_cond_t c, input cp_pkg::cp_pc_t dst);
        cfg_write(320 + t * 2 + s, make_entry(1'b1, can, c, dst, m_pc[t] + 8'd3), 1'b0);
        run_cycles(16);
    endtask

    task automatic set_flags(input logic co, input logic ov, input logic ae, input logic be,
                             input cp_pkg::cp_word_t r);
        d_co = co;
        d_ov = ov;
        d_ae = ae;
        d_be = be;
        d_r  = r;
    endtask

    // ------------------------------------------------------------
    // Tests

    task automatic reset_sequence();
        int waits;
        waits = 0;
        while (!rst_n) begin
            if (waits > 20)
                abort_run("reset was never released");
            @(negedge clock);
            waits++;
        end
        compare_outputs();
        model_cycle();
        waits = 0;
        while (!out_valid) begin
            if (waits > 10)
                abort_run("out_valid never rose after reset");
            step();
            waits++;
        end
        if (waits != 2)
            abort_run($sformatf("out_valid rose %0d cycles after reset, not 2", waits));
        run_cycles(8);
    endtask

    task automatic fetch_decode();
        for (int i = 0; i < 256; i++)
            cfg_write(i, (32'h9e3779b1 * (i + 1)) ^ (i << 13), 1'b0);
        for (int i = 0; i < 64; i++)
            cfg_write(256 + i, $urandom, 1'b0);
        run_cycles(40);
    endtask

    task automatic unconditional_branches();
        branch_ahead(2, 0, 1'b1, cp_pkg::COND_ALWAYS, 8'h90);
        cfg_write(320 + 4, 32'd0, 1'b0);
        branch_ahead(2, 1, 1'b0, cp_pkg::COND_ALWAYS, 8'h20);
        branch_ahead(3, 0, 1'b1, cp_pkg::COND_NEVER, 8'h10);
    endtask

    task automatic conditional_branches();
        for (int c = 1; c < 7; c++) begin
            for (int taken = 0; taken < 2; taken++) begin
                case (c)
                    1: set_flags(1'b0, 1'b0, 1'b0, 1'b0, taken ? 32'h8000_0001 : 32'h0000_0001);
                    2: set_flags(taken[0], 1'b0, 1'b0, 1'b0, 32'h1);
                    3: set_flags(1'b0, 1'b0, taken[0], 1'b0, 32'h1);
                    4: set_flags(1'b0, 1'b1, 1'b0, 1'b0, taken ? 32'h0000_0005 : 32'hf000_0000);
                    5: set_flags(1'b0, 1'b0, 1'b0, taken[0], 32'h1);
                    default: set_flags(1'b0, 1'b0, 1'b0, 1'b0, taken ? 32'h0 : 32'h100);
                endcase
                branch_ahead(1, 0, taken[0], cp_pkg::cp_branch_cond_t'(c), 8'(8'h40 + c));
            end
        end
        // Both entries match and slot 0 wins
        set_flags(1'b0, 1'b0, 1'b0, 1'b0, 32'h1);
        cfg_write(320 + 1, make_entry(1'b1, 1'b0, cp_pkg::COND_ALWAYS, 8'hc0, m_pc[0] + 8'd3),
                  1'b0);
        branch_ahead(0, 0, 1'b1, cp_pkg::COND_ALWAYS, 8'h80);
    endtask

    task automatic suppressed_writes();
        cfg_write(int'(m_pc[0] + 8'd2), 32'hdead_beef, 1'b1);
        cfg_write(256 + int'(m_im[m_pc[0] + 8'd2][31:28]), 32'hfff, 1'b1);
        // Out of every window, but aliasing addresses the threads are about to use
        cfg_write(512 + int'(m_pc[1] + 8'd2), 32'h0012_3456, 1'b0);
        cfg_write(1023, make_entry(1'b1, 1'b1, cp_pkg::COND_ALWAYS, 8'h00, m_pc[3] + 8'd2),
                  1'b0);
        run_cycles(16);
    endtask

    task automatic random_run();
        int t;
        for (int i = 0; i < 400; i++) begin
            set_flags(1'($urandom), 1'($urandom), 1'($urandom), 1'($urandom),
                      ($urandom % 4 == 0) ? 32'd0 : $urandom);
            if ($urandom % 12 == 0) begin
                t    = $urandom % 4;
                d_cw = 1'b1;
                d_cp = ($urandom % 8 == 0);
                d_ca = cp_pkg::cp_addr_t'(320 + t * 2 + $urandom % 2);
                d_cd = make_entry($urandom % 4 != 0, 1'($urandom),
                                  cp_pkg::cp_branch_cond_t'($urandom % 8),
                                  8'($urandom), m_pc[t] + 8'($urandom % 3));
            end
            step();
        end
    endtask

    // ------------------------------------------------------------

    initial begin
        void'($urandom(56835));
        config_write    <= 1'b0;
        cancel_previous <= 1'b0;
        config_addr     <= '0;
        config_data     <= '0;
        carryout        <= 1'b0;
        overflow        <= 1'b0;
        a_external      <= 1'b0;
        b_external      <= 1'b0;
        r_previous      <= '0;
        d_cw = 1'b0;
        d_cp = 1'b0;
        d_co = 1'b0;
        d_ov = 1'b0;
        d_ae = 1'b0;
        d_be = 1'b0;
        d_ca = '0;
        d_cd = '0;
        d_r  = '0;
        for (int i = 0; i < 256; i++)
            m_im[i] = '0;
        for (int i = 0; i < 64; i++)
            m_od[i / 16][i % 16] = '0;
        for (int t = 0; t < 4; t++)
            m_pc[t] = cp_pkg::cp_pc_t'(t * `CP_THREAD_PC_STRIDE);
        for (int e = 0; e < 8; e++) begin
            m_en[e]   = 1'b0;
            m_can[e]  = 1'b0;
            m_org[e]  = '0;
            m_dst[e]  = '0;
            m_cond[e] = cp_pkg::COND_NEVER;
        end
        ncyc      = 0;
        s1_instr  = '0;
        s1_thread = '0;
        s1_cancel = 1'b0;
        e_valid   = 1'b0;
        e_cancel  = 1'b0;
        e_thread  = '0;
        e_alu     = '0;
        e_da      = '0;
        e_db      = '0;
        e_a       = '0;
        e_b       = '0;

        reset_sequence();
        fetch_decode();
        unconditional_branches();
        conditional_branches();
        suppressed_writes();
        random_run();
        $display("test passed");
        $finish;
    end

    // Overall limit on the run
    initial begin
        #2_000_000;
        abort_run("simulation ran past its time limit");
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hw
hw/cp_pkg.sv
hw/thread_scheduler.sv
hw/pc_store.sv
hw/branch_unit.sv
hw/instr_fetch_decode.sv
hw/controlpath.sv
dv/tb_clock_gen.sv
dv/controlpath_tb.sv

/* Bender.yml */
package:
  name: controlpath

sources:
  - include_dirs:
      - hw
    files:
      - hw/cp_pkg.sv
      - hw/thread_scheduler.sv
      - hw/pc_store.sv
      - hw/branch_unit.sv
      - hw/instr_fetch_decode.sv
      - hw/controlpath.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/tb_clock_gen.sv
      - dv/controlpath_tb.sv
